// ==== app_params.svh ====
`ifndef APP_PARAMS_SVH
`define APP_PARAMS_SVH

// message link and DRAM native interface
`define APP_XB_SIZE     32
`define APP_DATA_WIDTH  32
`define APP_ADDR_WIDTH  27
`define APP_ADDR_INC    8   // two-beat burst of 32-bit words

// pixel format
`define APP_DN_SIZE     12

// frame and patch geometry
`define APP_FRAME_COLS  8
`define APP_FRAME_ROWS  8
`define APP_PATCH_SIZE  4   // square patch edge, must divide both frame edges

// coefficient FIFO
`define APP_FIFO_DEPTH  16
`define APP_FIFO_HIGH   12  // prefetch pauses at this fill

`endif

// ==== app_pkg.sv ====
`include "app_params.svh"

package app_pkg;

  typedef logic [`APP_XB_SIZE-1:0]    msg_t;
  typedef logic [`APP_DATA_WIDTH-1:0] dram_word_t;
  typedef logic [`APP_ADDR_WIDTH-1:0] dram_addr_t;
  typedef logic [`APP_DN_SIZE-1:0]    dn_t;
  typedef logic [2*`APP_DN_SIZE-1:0]  coeff_pair_t; // dark for dn0 in the upper half
  typedef logic [23:0]                pix_sum_t;
  typedef logic [3:0]                 row_t;
  typedef logic [3:0]                 col_t;

  // message kind, top two bits of every message and stored DRAM word
  typedef enum logic [1:0] {
    kind_pixel    = 2'd0,
    kind_coeff    = 2'd1,
    kind_reserved = 2'd2,
    kind_invalid  = 2'd3
  } msg_kind_t;

  typedef enum logic [2:0] {
    dram_msg_wait, dram_wr_wait, dram_wr1, dram_wr2,
    dram_reading, dram_throttled, dram_interframe, dram_error
  } dram_state_t;

  typedef enum logic [2:0] {
    cap_standby, cap_intraline, cap_interline, cap_interframe, cap_error
  } capture_state_t;

endpackage

// ==== application.sv ====
module application (
  input  logic                dram_clk,
  input  logic                reset,
  output logic                error,
  input  logic                app_rdy,
  output logic                app_en,
  output logic [2:0]          app_cmd,
  output app_pkg::dram_addr_t app_addr,
  input  logic                app_wdf_rdy,
  output logic                app_wdf_wren,
  output logic                app_wdf_end,
  output app_pkg::dram_word_t app_wdf_data,
  input  logic                app_rd_data_valid,
  input  app_pkg::dram_word_t app_rd_data,
  input  logic                pc_msg_pending,
  output logic                pc_msg_ack,
  input  app_pkg::msg_t       pc_msg,
  input  logic                fpga_msg_full,
  output logic                fpga_msg_valid,
  output app_pkg::msg_t       fpga_msg
);

  logic                 pix_take;
  logic                 fifo_push;
  app_pkg::coeff_pair_t fifo_din;
  app_pkg::coeff_pair_t fifo_dout;
  logic                 fifo_full;
  logic                 fifo_high;
  logic                 fifo_empty;
  logic                 coeff_pop;
  logic                 frame_end;
  logic                 sum_valid;
  app_pkg::row_t        sum_row;
  app_pkg::col_t        sum_col;
  app_pkg::pix_sum_t    sum_pair;
  logic                 ifc_error;
  logic                 pipe_error;
  logic                 reducer_error;

  assign error = ifc_error | pipe_error | reducer_error;

  dram_ifc u_dram_ifc (
    .dram_clk(dram_clk), .reset(reset),
    .pc_msg_pending(pc_msg_pending), .pc_msg(pc_msg),
    .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
    .fifo_full(fifo_full), .fifo_high(fifo_high), .frame_end(frame_end),
    .pc_msg_ack(pc_msg_ack), .pix_take(pix_take),
    .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
    .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .fifo_push(fifo_push), .fifo_din(fifo_din), .error(ifc_error)
  );

  coeff_fifo u_coeff_fifo (
    .dram_clk(dram_clk), .reset(reset),
    .push(fifo_push), .din(fifo_din), .pop(coeff_pop),
    .dout(fifo_dout), .full(fifo_full), .high(fifo_high), .empty(fifo_empty)
  );

  pixel_pipe u_pixel_pipe (
    .dram_clk(dram_clk), .reset(reset),
    .pix_take(pix_take), .pc_msg(pc_msg), .coeff(fifo_dout), .coeff_empty(fifo_empty),
    .coeff_pop(coeff_pop), .sum_valid(sum_valid), .sum_row(sum_row), .sum_col(sum_col),
    .sum_pair(sum_pair), .frame_end(frame_end), .error(pipe_error)
  );

  patch_reducer u_patch_reducer (
    .dram_clk(dram_clk), .reset(reset),
    .sum_valid(sum_valid), .sum_row(sum_row), .sum_col(sum_col), .sum_pair(sum_pair),
    .fpga_msg_full(fpga_msg_full),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg), .error(reducer_error)
  );

endmodule

// ==== application_asserts.sv ====
module application_asserts (
  input logic                dram_clk,
  input logic                reset,
  input logic                app_en,
  input logic                app_wdf_rdy,
  input logic                app_wdf_wren,
  input logic                app_wdf_end,
  input logic                pc_msg_ack,
  input logic                error,
  input app_pkg::dram_state_t dram_state
);
  timeunit 1ns;
  timeprecision 1ps;

  // a taken first beat is followed by the closing beat
  assert property (@(posedge dram_clk) disable iff (reset)
    (app_wdf_wren && $past(app_wdf_wren && !app_wdf_end && app_wdf_rdy)) |-> app_wdf_end)
    else $error("second write beat without app_wdf_end");

  assert property (@(posedge dram_clk) disable iff (reset) pc_msg_ack |=> !pc_msg_ack)
    else $error("pc_msg_ack high two cycles in a row");

  assert property (@(posedge dram_clk) disable iff (reset)
    (dram_state == app_pkg::dram_throttled) |-> !app_en)
    else $error("app_en high while throttled");

  assert property (@(posedge dram_clk) disable iff (reset) error |=> error)
    else $error("error fell without reset");

endmodule

bind application application_asserts u_application_asserts (
  .dram_clk(dram_clk), .reset(reset), .app_en(app_en), .app_wdf_rdy(app_wdf_rdy),
  .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .pc_msg_ack(pc_msg_ack),
  .error(error), .dram_state(u_dram_ifc.state)
);

// ==== coeff_fifo.sv ====
`include "app_params.svh"

module coeff_fifo (
  input  logic                dram_clk,
  input  logic                reset,
  input  logic                push,
  input  app_pkg::coeff_pair_t din,
  input  logic                pop,
  output app_pkg::coeff_pair_t dout,
  output logic                full,
  output logic                high,
  output logic                empty
);

  localparam int PTR_W = $clog2(`APP_FIFO_DEPTH);
  localparam logic [PTR_W:0] DEPTH = `APP_FIFO_DEPTH;
  localparam logic [PTR_W:0] HIGH_MARK = `APP_FIFO_HIGH;

  app_pkg::coeff_pair_t mem [`APP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;  // overflow is flagged upstream
  assign do_pop  = pop && !empty;

  assign dout  = mem[rd_ptr];  // head word is visible before the pop
  assign full  = (fill == DEPTH);
  assign high  = (fill >= HIGH_MARK);
  assign empty = (fill == '0);

  always_ff @(posedge dram_clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, pointers wrap
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

// ==== dram_ifc.sv ====
`include "app_params.svh"

module dram_ifc (
  input  logic                 dram_clk,
  input  logic                 reset,
  input  logic                 pc_msg_pending,
  input  app_pkg::msg_t        pc_msg,
  input  logic                 app_rdy,
  input  logic                 app_wdf_rdy,
  input  logic                 app_rd_data_valid,
  input  app_pkg::dram_word_t  app_rd_data,
  input  logic                 fifo_full,
  input  logic                 fifo_high,
  input  logic                 frame_end,
  output logic                 pc_msg_ack,
  output logic                 pix_take,
  output logic                 app_en,
  output logic [2:0]           app_cmd,
  output app_pkg::dram_addr_t  app_addr,
  output logic                 app_wdf_wren,
  output logic                 app_wdf_end,
  output app_pkg::dram_word_t  app_wdf_data,
  output logic                 fifo_push,
  output app_pkg::coeff_pair_t fifo_din,
  output logic                 error
);

  localparam app_pkg::dram_addr_t ADDR_INC = `APP_ADDR_INC;

  app_pkg::dram_state_t state;
  app_pkg::msg_kind_t   msg_kind;
  app_pkg::msg_kind_t   rd_kind;
  app_pkg::dram_word_t  burst_buf [2];
  app_pkg::dram_addr_t  end_addr;   // first address past the last written burst
  app_pkg::dram_addr_t  next_addr;
  logic                 half_loaded;
  logic                 rd;
  logic                 coeff_take;

  assign msg_kind  = app_pkg::msg_kind_t'(pc_msg[`APP_XB_SIZE-1 -: 2]);
  assign rd_kind   = app_pkg::msg_kind_t'(app_rd_data[`APP_DATA_WIDTH-1 -: 2]);
  assign next_addr = app_addr + ADDR_INC;

  // the ack cycle blocks a second take of the same pending message
  assign coeff_take = pc_msg_pending && !pc_msg_ack && msg_kind == app_pkg::kind_coeff
                      && state == app_pkg::dram_msg_wait;
  assign pix_take = pc_msg_pending && !pc_msg_ack && msg_kind == app_pkg::kind_pixel
                    && state inside {app_pkg::dram_msg_wait, app_pkg::dram_reading,
                                     app_pkg::dram_throttled, app_pkg::dram_interframe};

  assign app_cmd   = {2'b00, rd};
  assign fifo_push = app_rd_data_valid && rd_kind == app_pkg::kind_coeff;
  assign fifo_din  = app_rd_data[2*`APP_DN_SIZE-1:0];

  always_ff @(posedge dram_clk) begin
    if (coeff_take) burst_buf[half_loaded] <= pc_msg;  // beat order = send order
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state        <= app_pkg::dram_msg_wait;
      pc_msg_ack   <= 1'b0;
      app_en       <= 1'b0;
      rd           <= 1'b0;
      app_addr     <= '0;
      end_addr     <= '0;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1;
      half_loaded  <= 1'b0;
      error        <= 1'b0;
    end else begin
      pc_msg_ack <= coeff_take || pix_take;
      if (fifo_push && fifo_full) error <= 1'b1;
      case (state)
        app_pkg::dram_msg_wait: begin
          if (coeff_take) begin
            half_loaded <= !half_loaded;
            if (half_loaded) begin  // second word of the burst is in
              app_addr <= end_addr;
              rd       <= 1'b0;
              app_en   <= 1'b1;
              state    <= app_pkg::dram_wr_wait;
            end
          end else if (pix_take) begin
            app_addr <= '0;
            rd       <= 1'b1;
            app_en   <= (end_addr != '0);  // nothing stored, nothing to prefetch
            state    <= (end_addr != '0) ? app_pkg::dram_reading : app_pkg::dram_interframe;
          end
        end
        app_pkg::dram_wr_wait: begin
          if (app_rdy && app_wdf_rdy) begin  // command accepted this edge
            app_en       <= 1'b0;
            end_addr     <= end_addr + ADDR_INC;
            app_wdf_data <= burst_buf[0];
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            state        <= app_pkg::dram_wr1;
          end
        end
        app_pkg::dram_wr1: begin
          if (app_wdf_rdy) begin
            app_wdf_data <= burst_buf[1];
            app_wdf_end  <= 1'b1;
            state        <= app_pkg::dram_wr2;
          end
        end
        app_pkg::dram_wr2: begin
          app_wdf_wren <= 1'b0;
          state <= app_wdf_rdy ? app_pkg::dram_msg_wait : app_pkg::dram_error;
        end
        app_pkg::dram_reading: begin
          if (app_rdy) app_addr <= next_addr;  // app_en is high throughout this state
          if (app_rdy && next_addr == end_addr) begin
            app_en <= 1'b0;
            state  <= app_pkg::dram_interframe;
          end else if (fifo_high) begin
            app_en <= 1'b0;
            state  <= app_pkg::dram_throttled;
          end
        end
        app_pkg::dram_throttled: begin
          if (!fifo_high) begin
            app_en <= 1'b1;
            state  <= app_pkg::dram_reading;
          end
        end
        app_pkg::dram_interframe: begin
          if (frame_end && end_addr != '0) begin  // same dark set for the next frame
            app_addr <= '0;
            app_en   <= 1'b1;
            state    <= app_pkg::dram_reading;
          end
        end
        app_pkg::dram_error: error <= 1'b1;
        default: state <= app_pkg::dram_error;
      endcase
    end
  end

endmodule

// ==== patch_reducer.sv ====
`include "app_params.svh"

module patch_reducer (
  input  logic              dram_clk,
  input  logic              reset,
  input  logic              sum_valid,
  input  app_pkg::row_t     sum_row,
  input  app_pkg::col_t     sum_col,
  input  app_pkg::pix_sum_t sum_pair,
  input  logic              fpga_msg_full,
  output logic              fpga_msg_valid,
  output app_pkg::msg_t     fpga_msg,
  output logic              error
);

  localparam int PATCH_COLS = `APP_FRAME_COLS / `APP_PATCH_SIZE;
  localparam int PCOL_W = (PATCH_COLS > 1) ? $clog2(PATCH_COLS) : 1;

  app_pkg::pix_sum_t acc [PATCH_COLS];  // one running sum per patch column
  app_pkg::pix_sum_t patch_total;
  logic [PCOL_W-1:0] pcol;
  logic [5:0]        patch_idx;
  logic              first_pair;
  logic              last_pair;
  logic              patch_done;
  logic              held;  // finished message waiting on fpga_msg_full

  assign pcol       = PCOL_W'(sum_col / `APP_PATCH_SIZE);
  assign first_pair = (sum_row % `APP_PATCH_SIZE == 0) && (sum_col % `APP_PATCH_SIZE == 0);
  assign last_pair  = (sum_row % `APP_PATCH_SIZE == `APP_PATCH_SIZE - 1)
                      && (sum_col % `APP_PATCH_SIZE == `APP_PATCH_SIZE - 2);
  assign patch_done  = sum_valid && last_pair;
  assign patch_total = acc[pcol] + sum_pair;
  assign patch_idx   = 6'((sum_row / `APP_PATCH_SIZE) * PATCH_COLS + pcol);  // band-major

  always_ff @(posedge dram_clk) begin
    if (sum_valid) acc[pcol] <= first_pair ? sum_pair : patch_total;
    if (patch_done && !held) fpga_msg <= {app_pkg::kind_coeff, patch_idx, patch_total};
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      fpga_msg_valid <= 1'b0;
      held           <= 1'b0;
      error          <= 1'b0;
    end else begin
      fpga_msg_valid <= 1'b0;
      if (patch_done) begin
        if (held) begin
          error <= 1'b1;  // only one message can wait
        end else if (fpga_msg_full) begin
          held <= 1'b1;
        end else begin
          fpga_msg_valid <= 1'b1;
        end
      end else if (held && !fpga_msg_full) begin
        held           <= 1'b0;
        fpga_msg_valid <= 1'b1;
      end
    end
  end

endmodule

// ==== pixel_pipe.sv ====
`include "app_params.svh"

module pixel_pipe (
  input  logic                 dram_clk,
  input  logic                 reset,
  input  logic                 pix_take,
  input  app_pkg::msg_t        pc_msg,
  input  app_pkg::coeff_pair_t coeff,
  input  logic                 coeff_empty,
  output logic                 coeff_pop,
  output logic                 sum_valid,
  output app_pkg::row_t        sum_row,
  output app_pkg::col_t        sum_col,
  output app_pkg::pix_sum_t    sum_pair,
  output logic                 frame_end,
  output logic                 error
);

  app_pkg::capture_state_t state;
  app_pkg::dn_t  dn0;
  app_pkg::dn_t  dn1;
  logic          fval;
  logic          lval;
  app_pkg::row_t row_cnt;  // position of the next line-valid pair
  app_pkg::col_t col_cnt;
  logic                 s1_valid;
  app_pkg::dn_t         s1_dn0;
  app_pkg::dn_t         s1_dn1;
  app_pkg::coeff_pair_t s1_dark;
  app_pkg::row_t        s1_row;
  app_pkg::col_t        s1_col;

  function automatic app_pkg::dn_t clamp_sub(input app_pkg::dn_t dn, input app_pkg::dn_t dark);
    return (dn > dark) ? app_pkg::dn_t'(dn - dark) : '0;
  endfunction

  assign {dn0, fval, lval, dn1} = pc_msg[2*`APP_DN_SIZE+1:0];
  assign coeff_pop = pix_take && lval && !coeff_empty;
  assign error     = (state == app_pkg::cap_error);  // only reset leaves this state

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state     <= app_pkg::cap_standby;
      row_cnt   <= '0;
      col_cnt   <= '0;
      frame_end <= 1'b0;
      s1_valid  <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      frame_end <= 1'b0;
      s1_valid  <= coeff_pop;
      sum_valid <= s1_valid;
      if (pix_take) begin
        if (lval) col_cnt <= col_cnt + 2'd2;  // two pixels per message
        case (state)
          app_pkg::cap_standby, app_pkg::cap_interframe:
            if (fval) state <= lval ? app_pkg::cap_intraline : app_pkg::cap_interline;
          app_pkg::cap_intraline, app_pkg::cap_interline: begin
            if (!fval) begin  // fval fell, frame is over
              frame_end <= 1'b1;
              row_cnt   <= '0;
              col_cnt   <= '0;
              state     <= app_pkg::cap_interframe;
            end else if (!lval && state == app_pkg::cap_intraline) begin
              row_cnt <= row_cnt + 1'b1;
              col_cnt <= '0;
              state   <= app_pkg::cap_interline;
            end else if (lval) begin
              state <= app_pkg::cap_intraline;
            end
          end
          default: ;
        endcase
        if (lval && coeff_empty) state <= app_pkg::cap_error;  // no dark pair for this pixel
      end
    end
  end

  // stage one registers the pair, stage two subtracts and sums
  always_ff @(posedge dram_clk) begin
    if (coeff_pop) begin
      s1_dn0  <= dn0;
      s1_dn1  <= dn1;
      s1_dark <= coeff;
      s1_row  <= row_cnt;
      s1_col  <= col_cnt;
    end
    if (s1_valid) begin
      sum_row  <= s1_row;
      sum_col  <= s1_col;
      sum_pair <= app_pkg::pix_sum_t'(clamp_sub(s1_dn0, s1_dark[2*`APP_DN_SIZE-1 -: `APP_DN_SIZE]))
                + app_pkg::pix_sum_t'(clamp_sub(s1_dn1, s1_dark[`APP_DN_SIZE-1:0]));
    end
  end

endmodule

// ==== tb_application.sv ====
`include "app_params.svh"

module tb_application;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    string name;
    int    coeff_mode;  // 0 small darks, 1 full range darks, 2 nothing loaded
    int    dn_mode;     // 0 LFSR pixels, 1 fixed pixels
    int    frames;
    bit    hold_full;
  } test_t;

  logic dram_clk = 0;
  logic reset = 1;
  logic error, app_en, app_wdf_wren, app_wdf_end, pc_msg_ack, fpga_msg_valid;
  logic [2:0] app_cmd;
  app_pkg::dram_addr_t app_addr;
  app_pkg::dram_word_t app_wdf_data;
  app_pkg::msg_t       fpga_msg;
  logic app_rdy = 0;
  logic app_wdf_rdy = 1;
  logic app_rd_data_valid = 0;
  app_pkg::dram_word_t app_rd_data = '0;
  logic pc_msg_pending = 0;
  app_pkg::msg_t pc_msg = '0;
  logic fpga_msg_full = 0;

  test_t tests[5];
  app_pkg::dram_word_t mem [app_pkg::dram_addr_t];  // DRAM model storage
  app_pkg::dram_word_t rd_q[$];
  app_pkg::dram_word_t exp_wr[$];  // coefficient messages in send order
  app_pkg::msg_t       got_q[$];
  app_pkg::coeff_pair_t darks[$];
  logic [15:0] rdy_lfsr = 16'd80;
  logic [15:0] data_lfsr = 16'd80;
  string cur_name;
  int rd_wait, wr_bursts, beats_back, lval_sent;
  int errors, checks, cycles, limit;
  app_pkg::dram_addr_t wr_addr;

  application u_application (.*);

  always #4 dram_clk = ~dram_clk;

  always @(posedge dram_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run passed %0d cycles without finishing", limit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [23:0] rand_bits(input int n);
    logic [23:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[22:0], data_lfsr[0]};
      data_lfsr = lfsr_next(data_lfsr);
    end
    return v;
  endfunction

  function automatic app_pkg::pix_sum_t clamp_diff(input app_pkg::dn_t dn,
                                                   input app_pkg::dn_t dark);
    int d;
    d = int'(dn) - int'(dark);
    return (d < 0) ? '0 : app_pkg::pix_sum_t'(d);
  endfunction

  task automatic check_msg(input string what, input app_pkg::msg_t exp, input app_pkg::msg_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %h, got %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_sum(input string what, input app_pkg::pix_sum_t exp,
                           input app_pkg::pix_sum_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %0d, got %0d", cur_name, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input app_pkg::dram_word_t exp,
                            input app_pkg::dram_word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %h, got %h", cur_name, what, exp, act);
    end
  endtask

  task automatic problem(input string text);
    errors++;
    $display("%s: %s", cur_name, text);
  endtask

  // DRAM model and fpga_msg monitor sample at the falling edge
  always begin
    logic rd_acc, wr_acc, beat, end_s;
    app_pkg::dram_addr_t addr_s;
    app_pkg::dram_word_t data_s;
    @(negedge dram_clk);
    rd_acc = app_en && app_rdy && app_cmd == 3'b001;
    wr_acc = app_en && app_rdy && app_wdf_rdy && app_cmd == 3'b000;
    beat   = app_wdf_wren && app_wdf_rdy;
    addr_s = app_addr;
    data_s = app_wdf_data;
    end_s  = app_wdf_end;
    if (fpga_msg_valid && !reset) got_q.push_back(fpga_msg);
    @(posedge dram_clk);
    #1;
    if (reset) begin
      rd_q.delete();
      rd_wait = 0;
      app_rd_data_valid = 0;
      app_rdy = 0;
    end else begin
      if (wr_acc) begin
        check_word("write address", app_pkg::dram_word_t'(wr_bursts * 8), 32'(addr_s));
        wr_addr = addr_s;
        wr_bursts++;
      end
      if (beat) begin
        if (exp_wr.size() == 0) problem("write beat with no coefficient message pending");
        else check_word("write beat", exp_wr.pop_front(), data_s);
        mem[wr_addr + (end_s ? 4 : 0)] = data_s;
      end
      if (rd_acc) begin
        rd_q.push_back(mem.exists(addr_s) ? mem[addr_s] : '0);
        rd_q.push_back(mem.exists(addr_s + 4) ? mem[addr_s + 4] : '0);
        rd_wait = 3;
      end
      app_rd_data_valid = 0;
      if (rd_wait > 0) begin
        rd_wait--;
      end else if (rd_q.size() > 0) begin
        app_rd_data = rd_q.pop_front();
        app_rd_data_valid = 1;
        if (app_rd_data[31:30] == app_pkg::kind_coeff) beats_back++;
      end
      rdy_lfsr = lfsr_next(rdy_lfsr);
      app_rdy = rdy_lfsr[0] && rd_q.size() == 0 && rd_wait == 0;
    end
  end

  task automatic send_msg(input app_pkg::msg_t m);
    int n;
    pc_msg = m;
    pc_msg_pending = 1;
    n = 0;
    do begin
      @(negedge dram_clk);
      n++;
    end while (!pc_msg_ack && n < 200);
    if (!pc_msg_ack) problem("pc_msg_ack never came");
    @(posedge dram_clk);
    #1;
    pc_msg_pending = 0;
  endtask

  task automatic send_pix(input app_pkg::dn_t dn0, input logic fval, input logic lval,
                          input app_pkg::dn_t dn1);
    send_msg({2'(app_pkg::kind_pixel), 4'b0, dn0, fval, lval, dn1});
  endtask

  task automatic run_test(input test_t t);
    app_pkg::pix_sum_t acc [4];
    app_pkg::coeff_pair_t pair;
    app_pkg::dn_t dn0, dn1;
    app_pkg::msg_t exp_q[$];
    app_pkg::msg_t got;
    int n, err_start, p;
    cur_name = t.name;
    err_start = errors;
    @(posedge dram_clk);
    #1;
    reset = 1;
    mem.delete();
    exp_wr.delete();
    got_q.delete();
    darks.delete();
    wr_bursts = 0;
    beats_back = 0;
    lval_sent = 0;
    fpga_msg_full = 0;
    repeat (16) @(posedge dram_clk);
    #1 reset = 0;
    if (t.coeff_mode < 2) begin
      for (int k = 0; k < `APP_FRAME_ROWS * `APP_FRAME_COLS / 2; k++) begin
        pair = (t.coeff_mode == 0) ? {4'b0, 8'(rand_bits(8)), 4'b0, 8'(rand_bits(8))}
                                   : rand_bits(24);
        darks.push_back(pair);
        exp_wr.push_back({2'(app_pkg::kind_coeff), 6'b0, pair});
        send_msg({2'(app_pkg::kind_coeff), 6'b0, pair});
      end
    end else begin
      // nothing stored so the first line-valid pixel has no dark pair
      send_pix('0, 1, 0, '0);
      send_pix(12'h100, 1, 1, 12'h100);
      repeat (2) @(negedge dram_clk);
      if (!error) problem("error not raised by a pixel with no coefficient");
      repeat (6) @(negedge dram_clk);
      if (!error) problem("error did not stay high");
      $display("test %s done, %0d errors", t.name, errors - err_start);
      return;
    end
    for (int f = 0; f < t.frames; f++) begin
      if (t.hold_full && f == 0) fpga_msg_full = 1;
      acc = '{default: '0};
      send_pix('0, 1, 0, '0);
      // prefetch runs up to the FIFO high mark before the first pixel
      n = 0;
      while (beats_back < lval_sent + `APP_FIFO_HIGH && n < 500) begin
        @(negedge dram_clk);
        n++;
      end
      if (n >= 500) problem("prefetch stopped before the coefficient FIFO high mark");
      for (int r = 0; r < `APP_FRAME_ROWS; r++) begin
        for (int j = 0; j < `APP_FRAME_COLS / 2; j++) begin
          n = 0;
          while (beats_back <= lval_sent && n < 500) begin
            @(negedge dram_clk);
            n++;
          end
          if (n >= 500) problem("coefficient read data stopped arriving");
          @(posedge dram_clk);
          #1;
          dn0 = (t.dn_mode == 0) ? rand_bits(12) : 12'h400;
          dn1 = (t.dn_mode == 0) ? rand_bits(12) : 12'h400;
          pair = darks[r * 4 + j];
          p = (r / `APP_PATCH_SIZE) * 2 + (2 * j) / `APP_PATCH_SIZE;
          acc[p] += clamp_diff(dn0, pair[23:12]) + clamp_diff(dn1, pair[11:0]);
          send_pix(dn0, 1, 1, dn1);
          lval_sent++;
          if (t.hold_full && f == 0 && r == 3 && j == 1) begin
            repeat (10) @(negedge dram_clk);
            if (got_q.size() != 0) problem("patch message sent while fpga_msg_full was high");
            @(posedge dram_clk);
            #1 fpga_msg_full = 0;
          end
        end
        send_pix('0, 1, 0, '0);
      end
      send_pix('0, 0, 0, '0);
      for (int i = 0; i < 4; i++) exp_q.push_back({2'(app_pkg::kind_coeff), 6'(i), acc[i]});
    end
    n = 0;
    while (got_q.size() < exp_q.size() && n < 300) begin
      @(negedge dram_clk);
      n++;
    end
    if (got_q.size() != exp_q.size())
      problem($sformatf("got %0d patch messages instead of %0d", got_q.size(), exp_q.size()));
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got = got_q.pop_front();
      check_msg("patch message", exp_q[0], got);
      check_sum("patch sum", exp_q.pop_front() & 24'hffffff, got[23:0]);
    end
    if (error) problem("error raised during a normal run");
    $display("test %s done, %0d errors", t.name, errors - err_start);
  endtask

  initial begin
    tests[0] = '{"lfsr_one_frame", 0, 0, 1, 0};
    tests[1] = '{"large_dark_clamp", 1, 1, 1, 0};
    tests[2] = '{"two_frames", 0, 0, 2, 0};
    tests[3] = '{"msg_full_hold", 0, 0, 1, 1};
    tests[4] = '{"no_coeff_error", 2, 0, 0, 0};
    limit = 0;
    foreach (tests[i]) limit += tests[i].frames * 2000 + 1500;
    foreach (tests[i]) run_test(tests[i]);
    $display("tests %0d, checks %0d, errors %0d", $size(tests), checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
app_pkg.sv
coeff_fifo.sv
dram_ifc.sv
pixel_pipe.sv
patch_reducer.sv
application.sv
application_asserts.sv
tb_application.sv
